/* source/key_pkg.sv */
// Keypad event definitions shared by the input controller, the control FSM and the top level
package key_pkg;

    // Event class presented by the keypad
    typedef enum logic [1:0] {
        KIND_DIGIT,
        KIND_OP,
        KIND_EQUAL
    } key_kind_t;

    typedef logic [3:0] digit_t;
    typedef logic [2:0] op_code_t;

    // Operator codes carried in the low bits of key_value
    localparam op_code_t OP_NONE = 3'd0;
    localparam op_code_t OP_NEG  = 3'd1;
    localparam op_code_t OP_ADD  = 3'd2;
    localparam op_code_t OP_SUB  = 3'd3;
    localparam op_code_t OP_MUL  = 3'd4;

    localparam int SYNC_STAGES = 2;

endpackage

/* source/num_pkg.sv */
// Number format and control FSM states, imported by the arithmetic units and the controller
package num_pkg;

    localparam int WORD_W = 16;

    // Sign in the top bit, magnitude below it
    typedef logic [WORD_W-1:0] word_t;
    typedef logic [WORD_W-2:0] mag_t;

    localparam int RADIX       = 10;
    localparam int MULT_CYCLES = 15;

    typedef enum logic [3:0] {
        WAIT_OP1,
        WAIT_MULT_OP1,
        ADD_KEY_OP1,
        WAIT_OP2,
        WAIT_MULT_OP2,
        ADD_KEY_OP2,
        SEND_TO_COMPUTE,
        WAIT_COMPUTE,
        SHOW_RESULT
    } state_t;

endpackage

/* source/keypad_sync.sv */
// Keypad input controller: takes one four-phase key request and presents it to gencon as levels
module keypad_sync
    import key_pkg::*;
(
    input  logic      clk,
    input  logic      nRST,
    input  logic      key_req,
    input  key_kind_t key_kind,
    input  logic [3:0] key_value,
    input  logic      key_read,
    output logic      key_ack,
    output digit_t    keypad_input,
    output logic      read_input,
    output op_code_t  operator_input,
    output logic      equal_input
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_PRESENT,
        S_ACKED
    } sync_state_t;

    sync_state_t state;
    logic [SYNC_STAGES-1:0] req_sync;
    logic req_s;
    logic req_q;
    logic req_rise;
    logic ev_valid;
    op_code_t key_code;

    assign req_s    = req_sync[SYNC_STAGES-1];
    assign req_rise = req_s & ~req_q;
    assign key_code = op_code_t'(key_value[2:0]);

    // An operator key with no code has nothing to present
    assign ev_valid = (key_kind == KIND_DIGIT) || (key_kind == KIND_EQUAL) ||
                      (key_kind == KIND_OP && key_code != OP_NONE);

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            req_sync <= '0;
            req_q    <= 1'b0;
        end else begin
            req_sync <= {req_sync[SYNC_STAGES-2:0], key_req};
            req_q    <= req_s;
        end
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state          <= S_IDLE;
            key_ack        <= 1'b0;
            read_input     <= 1'b0;
            operator_input <= OP_NONE;
            equal_input    <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (req_rise && ev_valid) begin
                        read_input     <= (key_kind == KIND_DIGIT);
                        equal_input    <= (key_kind == KIND_EQUAL);
                        operator_input <= (key_kind == KIND_OP) ? key_code : OP_NONE;
                        state          <= S_PRESENT;
                    end else if (req_rise) begin
                        // Nothing for gencon, acknowledge at once
                        key_ack <= 1'b1;
                        state   <= S_ACKED;
                    end
                end
                S_PRESENT: begin
                    if (key_read) begin
                        read_input     <= 1'b0;
                        equal_input    <= 1'b0;
                        operator_input <= OP_NONE;
                        key_ack        <= 1'b1;
                        state          <= S_ACKED;
                    end
                end
                S_ACKED: begin
                    if (!req_s) begin
                        key_ack <= 1'b0;
                        state   <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_IDLE && req_rise) begin
            keypad_input <= key_value;
        end
    end

endmodule

/* source/sm_addsub.sv */
// Sign-magnitude adder/subtractor, result and finish registered one cycle after start
module sm_addsub
    import num_pkg::*;
(
    input  logic  clk,
    input  logic  nRST,
    input  word_t in1,
    input  word_t in2,
    input  logic  sub,
    input  logic  start,
    output word_t out,
    output logic  finish
);

    logic a_sign;
    logic b_sign;
    logic r_sign;
    mag_t a_mag;
    mag_t b_mag;
    mag_t r_mag;

    always_comb begin
        a_sign = in1[WORD_W-1];
        b_sign = in2[WORD_W-1] ^ sub;
        a_mag  = in1[WORD_W-2:0];
        b_mag  = in2[WORD_W-2:0];
        if (a_sign == b_sign) begin
            // Carry out of the magnitude is dropped
            r_mag  = a_mag + b_mag;
            r_sign = a_sign;
        end else if (a_mag >= b_mag) begin
            r_mag  = a_mag - b_mag;
            r_sign = a_sign;
        end else begin
            r_mag  = b_mag - a_mag;
            r_sign = b_sign;
        end
        if (r_mag == '0) begin
            r_sign = 1'b0;
        end
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            finish <= 1'b0;
        end else begin
            finish <= start;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            out <= {r_sign, r_mag};
        end
    end

endmodule

/* source/shift_add_mult.sv */
// Iterative sign-magnitude multiplier, one shift-and-add step per cycle, low 15 bits kept
module shift_add_mult
    import num_pkg::*;
(
    input  logic  clk,
    input  logic  nRST,
    input  word_t in1,
    input  word_t in2,
    input  logic  start,
    output word_t out,
    output logic  finish
);

    localparam int CNT_W = $clog2(MULT_CYCLES + 1);

    logic [CNT_W-1:0] cnt;
    mag_t multiplicand;
    mag_t multiplier;
    mag_t acc;
    mag_t acc_next;
    logic prod_sign;

    // Bits shifted past the top are outside the kept product anyway
    assign acc_next = multiplier[0] ? acc + multiplicand : acc;

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            cnt    <= '0;
            finish <= 1'b0;
        end else begin
            finish <= 1'b0;
            if (start) begin
                cnt <= CNT_W'(MULT_CYCLES);
            end else if (cnt != '0) begin
                cnt <= cnt - 1'b1;
                if (cnt == CNT_W'(1)) begin
                    finish <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            multiplicand <= in1[WORD_W-2:0];
            multiplier   <= in2[WORD_W-2:0];
            prod_sign    <= in1[WORD_W-1] ^ in2[WORD_W-1];
            acc          <= '0;
        end else if (cnt != '0) begin
            multiplicand <= multiplicand << 1;
            multiplier   <= multiplier >> 1;
            acc          <= acc_next;
            if (cnt == CNT_W'(1)) begin
                // Zero product shown positive
                out <= {prod_sign & (acc_next != '0), acc_next};
            end
        end
    end

endmodule

/* source/gencon.sv */
// Calculator control FSM: builds both operands from keys, runs the arithmetic and drives the display
module gencon
    import key_pkg::*;
    import num_pkg::*;
(
    input  logic     clk,
    input  logic     nRST,
    input  digit_t   keypad_input,
    input  logic     read_input,
    input  op_code_t operator_input,
    input  logic     equal_input,
    output logic     key_read,
    output logic     complete,
    output word_t    display_output
);

    state_t state;
    state_t next_state;

    word_t    operand1;
    word_t    operand2;
    word_t    cur_operand;
    op_code_t op_q;
    digit_t   digit_q;

    // Shared operand registers for both units
    word_t unit_in1;
    word_t unit_in2;
    logic  sub;
    logic  start_add;
    logic  start_mult;
    word_t add_out;
    word_t mult_out;
    logic  add_finish;
    logic  mult_finish;

    logic waiting;
    logic take;
    logic load_digit;
    logic is_arith;

    sm_addsub add_unit (
        .clk    (clk),
        .nRST   (nRST),
        .in1    (unit_in1),
        .in2    (unit_in2),
        .sub    (sub),
        .start  (start_add),
        .out    (add_out),
        .finish (add_finish)
    );

    shift_add_mult mult_unit (
        .clk    (clk),
        .nRST   (nRST),
        .in1    (unit_in1),
        .in2    (unit_in2),
        .start  (start_mult),
        .out    (mult_out),
        .finish (mult_finish)
    );

    // Digit goes into the magnitude, sign kept
    function automatic word_t add_digit(input word_t w, input digit_t d);
        add_digit = {w[WORD_W-1], w[WORD_W-2:0] + mag_t'(d)};
    endfunction

    assign waiting     = (state == WAIT_OP1) || (state == WAIT_OP2);
    assign cur_operand = (state == WAIT_OP2) ? operand2 : operand1;
    assign is_arith    = operator_input inside {OP_ADD, OP_SUB, OP_MUL};

    // key_read high means the level still showing is the event just taken
    assign take = waiting && !key_read &&
                  (read_input || equal_input || operator_input != OP_NONE);
    assign load_digit = take && read_input;

    always_comb begin
        next_state = state;
        case (state)
            WAIT_OP1: begin
                if (take && read_input) begin
                    next_state = WAIT_MULT_OP1;
                end else if (take && is_arith) begin
                    next_state = WAIT_OP2;
                end
            end
            WAIT_MULT_OP1: if (mult_finish) next_state = ADD_KEY_OP1;
            ADD_KEY_OP1: next_state = WAIT_OP1;
            WAIT_OP2: begin
                if (take && read_input) begin
                    next_state = WAIT_MULT_OP2;
                end else if (take && equal_input) begin
                    next_state = SEND_TO_COMPUTE;
                end
            end
            WAIT_MULT_OP2: if (mult_finish) next_state = ADD_KEY_OP2;
            ADD_KEY_OP2: next_state = WAIT_OP2;
            SEND_TO_COMPUTE: next_state = WAIT_COMPUTE;
            WAIT_COMPUTE: if (add_finish || mult_finish) next_state = SHOW_RESULT;
            SHOW_RESULT: next_state = WAIT_OP1;
            default: next_state = WAIT_OP1;
        endcase
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state          <= WAIT_OP1;
            key_read       <= 1'b0;
            complete       <= 1'b0;
            display_output <= '0;
            operand1       <= '0;
            operand2       <= '0;
            op_q           <= OP_NONE;
            start_add      <= 1'b0;
            start_mult     <= 1'b0;
        end else begin
            state      <= next_state;
            key_read   <= take;
            complete   <= (state == SHOW_RESULT);
            start_mult <= load_digit || (state == SEND_TO_COMPUTE && op_q == OP_MUL);
            start_add  <= (state == SEND_TO_COMPUTE && op_q != OP_MUL);
            case (state)
                WAIT_OP1: begin
                    if (take && operator_input == OP_NEG) begin
                        operand1[WORD_W-1] <= ~operand1[WORD_W-1];
                    end else if (take && is_arith) begin
                        op_q <= operator_input;
                    end
                end
                WAIT_MULT_OP1: begin
                    if (mult_finish) begin
                        operand1 <= {operand1[WORD_W-1], mult_out[WORD_W-2:0]};
                    end
                end
                ADD_KEY_OP1: operand1 <= add_digit(operand1, digit_q);
                WAIT_OP2: begin
                    // Further arithmetic operators are dropped, no chaining
                    if (take && operator_input == OP_NEG) begin
                        operand2[WORD_W-1] <= ~operand2[WORD_W-1];
                    end
                end
                WAIT_MULT_OP2: begin
                    if (mult_finish) begin
                        operand2 <= {operand2[WORD_W-1], mult_out[WORD_W-2:0]};
                    end
                end
                ADD_KEY_OP2: operand2 <= add_digit(operand2, digit_q);
                SHOW_RESULT: begin
                    display_output <= (op_q == OP_MUL) ? mult_out : add_out;
                    operand1       <= '0;
                    operand2       <= '0;
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (load_digit) begin
            digit_q  <= keypad_input;
            unit_in1 <= cur_operand;
            unit_in2 <= word_t'(RADIX);
        end else if (state == SEND_TO_COMPUTE) begin
            unit_in1 <= operand1;
            unit_in2 <= operand2;
            sub      <= (op_q == OP_SUB);
        end
    end

endmodule

/* source/calc_top.sv */
// Calculator top level joining the keypad input controller to the control FSM
module calc_top
    import key_pkg::*;
    import num_pkg::*;
(
    input  logic       clk,
    input  logic       nRST,
    input  logic       key_req,
    input  key_kind_t  key_kind,
    input  logic [3:0] key_value,
    output logic       key_ack,
    output logic       complete,
    output word_t      display_output
);

    digit_t   keypad_input;
    logic     read_input;
    op_code_t operator_input;
    logic     equal_input;
    logic     key_read;

    keypad_sync keypad_sync_i (
        .clk            (clk),
        .nRST           (nRST),
        .key_req        (key_req),
        .key_kind       (key_kind),
        .key_value      (key_value),
        .key_read       (key_read),
        .key_ack        (key_ack),
        .keypad_input   (keypad_input),
        .read_input     (read_input),
        .operator_input (operator_input),
        .equal_input    (equal_input)
    );

    gencon gencon_i (
        .clk            (clk),
        .nRST           (nRST),
        .keypad_input   (keypad_input),
        .read_input     (read_input),
        .operator_input (operator_input),
        .equal_input    (equal_input),
        .key_read       (key_read),
        .complete       (complete),
        .display_output (display_output)
    );

endmodule

/* testbench/calc_props.sv */
// Concurrent checks on the keypad handshake and the complete pulse, bound into calc_top
module calc_props (
    input logic clk,
    input logic nRST,
    input logic key_req,
    input logic key_ack,
    input logic complete,
    input logic equal_input,
    input logic key_read
);

    logic equal_seen;

    // Set once gencon has taken an equals event
    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            equal_seen <= 1'b0;
        end else if (equal_input && key_read) begin
            equal_seen <= 1'b1;
        end
    end

    ack_needs_req: assert property (@(posedge clk) disable iff (!nRST)
        $rose(key_ack) |-> key_req)
        else $error("key_ack rose while key_req was low");

    complete_single: assert property (@(posedge clk) disable iff (!nRST)
        complete |=> !complete)
        else $error("complete stayed high for two cycles");

    complete_after_equal: assert property (@(posedge clk) disable iff (!nRST)
        !equal_seen |-> !complete)
        else $error("complete rose before any equals event was taken");

endmodule

bind calc_top calc_props calc_props_i (
    .clk         (clk),
    .nRST        (nRST),
    .key_req     (key_req),
    .key_ack     (key_ack),
    .complete    (complete),
    .equal_input (equal_input),
    .key_read    (key_read)
);

/* testbench/tb_calc.sv */
// Calculator testbench: replays key events from the vectors file and checks each shown result
module tb_calc
    import key_pkg::*;
    import num_pkg::*;
();

    localparam int VEC_DEPTH         = 256;
    localparam int CYCLES_PER_RECORD = 200;

    localparam logic [3:0] REC_DIGIT  = 4'h0;
    localparam logic [3:0] REC_OP     = 4'h1;
    localparam logic [3:0] REC_EQUAL  = 4'h2;
    localparam logic [3:0] REC_RESULT = 4'h3;
    localparam logic [3:0] REC_NONE   = 4'h4;
    localparam logic [3:0] REC_END    = 4'hF;

    logic       clk;
    logic       nRST;
    logic       key_req;
    key_kind_t  key_kind;
    logic [3:0] key_value;
    logic       key_ack;
    logic       complete;
    word_t      display_output;

    logic [23:0] vectors [VEC_DEPTH];
    int    n_records = 0;
    int    result_count = 0;
    int    checked_count = 0;
    word_t last_result;

    calc_top calc_top_i (
        .clk            (clk),
        .nRST           (nRST),
        .key_req        (key_req),
        .key_kind       (key_kind),
        .key_value      (key_value),
        .key_ack        (key_ack),
        .complete       (complete),
        .display_output (display_output)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Catch every complete pulse, even one that lands inside a handshake
    always @(posedge clk) begin
        if (complete) begin
            result_count <= result_count + 1;
            last_result  <= display_output;
        end
    end

    initial begin
        wait (n_records != 0);
        repeat (n_records * CYCLES_PER_RECORD) @(posedge clk);
        $display("Timeout: the vectors did not finish within %0d cycles",
                 n_records * CYCLES_PER_RECORD);
        $display("ERRORS FOUND");
        $fatal(1);
    end

    function automatic string test_name(input logic [3:0] id);
        case (id)
            4'd1:    test_name = "add_multi_digit";
            4'd2:    test_name = "sub_sign_and_zero";
            4'd3:    test_name = "negate_and_multiply";
            4'd4:    test_name = "magnitude_overflow";
            4'd5:    test_name = "ignored_equals";
            4'd6:    test_name = "operands_cleared";
            default: test_name = "unnamed";
        endcase
    endfunction

    // Full four-phase exchange for one key event
    task automatic send_key(input key_kind_t kind, input logic [3:0] value);
        @(posedge clk);
        key_kind  <= kind;
        key_value <= value;
        @(posedge clk);
        key_req <= 1'b1;
        while (!key_ack) @(posedge clk);
        key_req <= 1'b0;
        while (key_ack) @(posedge clk);
    endtask

    task automatic check_result(input logic [3:0] id, input word_t expected);
        while (result_count == checked_count) @(posedge clk);
        checked_count++;
        assert (last_result == expected) else begin
            $display("[FAIL] %s: expected %h, actual %h", test_name(id), expected, last_result);
            $display("ERRORS FOUND");
            $fatal(1);
        end
    endtask

    task automatic check_no_result(input logic [3:0] id);
        assert (result_count == checked_count) else begin
            $display("[FAIL] %s: expected %0d results, actual %0d",
                     test_name(id), checked_count, result_count);
            $display("ERRORS FOUND");
            $fatal(1);
        end
    endtask

    task automatic run_record(input logic [23:0] rec, input int index);
        logic [3:0] kind;
        logic [3:0] id;
        logic [15:0] value;
        kind  = rec[23:20];
        id    = rec[19:16];
        value = rec[15:0];
        case (kind)
            REC_DIGIT:  send_key(KIND_DIGIT, value[3:0]);
            REC_OP:     send_key(KIND_OP, value[3:0]);
            REC_EQUAL:  send_key(KIND_EQUAL, 4'd0);
            REC_RESULT: check_result(id, value);
            REC_NONE:   check_no_result(id);
            default: begin
                $display("Unknown record type %h at vector entry %0d", kind, index);
                $display("ERRORS FOUND");
                $fatal(1);
            end
        endcase
    endtask

    initial begin
        int count;
        nRST      = 1'b0;
        key_req   = 1'b0;
        key_kind  = KIND_DIGIT;
        key_value = 4'd0;
        $readmemh("testbench/calc_vectors.txt", vectors);
        count = 0;
        while (count < VEC_DEPTH && vectors[count][23:20] != REC_END) begin
            count++;
        end
        if (count == VEC_DEPTH || count == 0) begin
            $display("The vector file is empty or has no end record");
            $display("ERRORS FOUND");
            $fatal(1);
        end
        n_records = count;
        repeat (16) @(posedge clk);
        nRST <= 1'b1;
        repeat (2) @(posedge clk);
        for (int i = 0; i < n_records; i++) begin
            run_record(vectors[i], i);
        end
        $display("NO ERRORS");
        $finish;
    end

endmodule

/* testbench/calc_vectors.txt */
// One 24-bit hex record per word: [23:20] type, [19:16] test id, [15:0] value
// Types: 0 digit, 1 operator, 2 equals, 3 expected display, 4 no result expected, F end
010001 010002 010003 110002 010004 010005 210000 3100A8
020007 120003 020001 020002 220000 328005
020009 120003 020009 220000 320000
030002 030005 130001 130004 030004 230000 338064
030003 130001 130004 030006 130001 230000 330012
040003 040000 040000 140004 040002 040000 040000 240000 346A60
040009 040009 040009 040009 040009 140002 040000 240000 34069F
250000 450000 050008 150004 050007 250000 350038
060002 160002 060003 260000 360005
060004 160004 060005 260000 360014
F00000

/* tb.f */
source/key_pkg.sv
source/num_pkg.sv
source/keypad_sync.sv
source/sm_addsub.sv
source/shift_add_mult.sv
source/gencon.sv
source/calc_top.sv
testbench/calc_props.sv
testbench/tb_calc.sv

/* Makefile */
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_calc

run: compile
	./obj_dir/Vtb_calc 2>&1 | tee $(LOG)
	grep -qx "NO ERRORS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
